// ==== source/prom_pkg.sv ====
// ==================================================
// PROM download package
// Shared types and constants for the ROM download
// path: PROM ids, download, program and PROM write
// records, and read requests
// ==================================================
`default_nettype none

package prom_pkg;

    localparam int DL_AW      = 22; // Download byte address width
    localparam int PROM_COUNT = 6;  // Colour and timing PROMs

    // First byte address owned by the PROMs
    localparam logic [DL_AW-1:0] PROG_REGION_END = DL_AW'(65536);

    typedef enum logic [2:0] {
        PROM_TIMING    = 3'd0, // 7J timing
        PROM_OBJ_PAL_B = 3'd1, // Object palette, bank B
        PROM_OBJ_PAL_A = 3'd2, // Object palette, bank A
        PROM_BACK_PAL  = 3'd3, // Background palette
        PROM_TXT_PAL   = 3'd4, // Text palette
        PROM_TXT       = 3'd5  // Text PROM
    } prom_id_e;

    typedef struct packed {
        logic [DL_AW-1:0] addr; // Byte address from loader
        logic [7:0]       data;
    } dl_write_t;

    typedef struct packed {
        logic [DL_AW-1:0] addr; // Word address
        logic [7:0]       data;
        logic [1:0]       mask; // Active low byte lanes
    } prog_write_t;

    typedef struct packed {
        logic [PROM_COUNT-1:0] sel;  // One-hot, bit order of prom_id_e
        logic [7:0]            addr; // Upper bits unused for small banks
        logic [7:0]            data;
    } prom_write_t;

    typedef struct packed {
        prom_id_e   id;
        logic [7:0] addr;
    } prom_read_t;

endpackage

`default_nettype wire

// ==== source/prom_download_decoder.sv ====
// ==================================================
// PROM download decoder
// Splits the loader byte stream into 16-bit program
// writes and one-hot PROM writes, one cycle later
// ==================================================
`timescale 1ns/10ps
`default_nettype none

module prom_download_decoder (
    input  wire                    clk_rgb,
    input  wire                    reset,
    input  wire                    downloading,
    input  wire                    dl_wr,
    input  wire prom_pkg::dl_write_t dl,
    output logic                   prog_we,
    output prom_pkg::prog_write_t  prog,
    output prom_pkg::prom_write_t  prom_wr
);

    logic                                 accept;   // Strobe during download
    logic                                 is_prog;  // Below PROM region
    prom_pkg::prom_id_e                   prom_id;  // Decoded target PROM
    logic [prom_pkg::PROM_COUNT-1:0]      prom_sel; // One-hot of prom_id

    assign accept  = dl_wr && downloading;
    assign is_prog = dl.addr < prom_pkg::PROG_REGION_END;

    // Address fields to PROM id
    always_comb begin
        if (!dl.addr[12]) begin
            prom_id = prom_pkg::PROM_TXT; // Text PROM window
        end else begin
            case (dl.addr[9:8])
                2'd0:    prom_id = prom_pkg::PROM_TIMING;
                2'd1:    prom_id = prom_pkg::PROM_OBJ_PAL_B;
                2'd2:    prom_id = prom_pkg::PROM_OBJ_PAL_A;
                default: prom_id = dl.addr[5] ? prom_pkg::PROM_TXT_PAL
                                              : prom_pkg::PROM_BACK_PAL;
            endcase
        end
    end

    assign prom_sel = prom_pkg::PROM_COUNT'(1) << prom_id;

    // Strobes last one cycle
    always_ff @(posedge clk_rgb) begin
        if (reset) begin
            prog_we     <= 1'b0;
            prom_wr.sel <= '0;
        end else begin
            prog_we     <= accept && is_prog;
            prom_wr.sel <= (accept && !is_prog) ? prom_sel : '0;
        end
    end

    // Payload follows the accepted byte
    always_ff @(posedge clk_rgb) begin
        if (accept && is_prog) begin
            prog.addr <= {1'b0, dl.addr[prom_pkg::DL_AW-1:1]}; // Byte to word
            prog.data <= dl.data;
            prog.mask <= {dl.addr[0], ~dl.addr[0]}; // Even byte in upper lane
        end
        if (accept && !is_prog) begin
            prom_wr.addr <= dl.addr[7:0];
            prom_wr.data <= dl.data;
        end
    end

endmodule

`default_nettype wire

// ==== source/prom_bank.sv ====
// ==================================================
// PROM bank
// Byte-wide PROM image, written by the download
// path and read through a registered port
// ==================================================
`timescale 1ns/10ps
`default_nettype none

module prom_bank #(
    parameter int PROM_AW = 8
) (
    input  wire               clk_rgb,
    input  wire               wr_en,
    input  wire [PROM_AW-1:0] wr_addr,
    input  wire [PROM_AW-1:0] rd_addr,
    input  wire [7:0]         wr_data,
    output logic [7:0]        rd_data
);

    logic [7:0] mem [2**PROM_AW]; // PROM contents

    always_ff @(posedge clk_rgb) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        rd_data <= mem[rd_addr]; // Read every cycle
    end

endmodule

`default_nettype wire

// ==== source/prom_read_mux.sv ====
// ==================================================
// PROM read mux
// Sends read requests to all banks and registers
// the byte of the requested PROM, two cycles after
// the request. Requests are dropped in download
// ==================================================
`timescale 1ns/10ps
`default_nettype none

module prom_read_mux #(
    parameter int PROM_AW = 8
) (
    input  wire                                clk_rgb,
    input  wire                                reset,
    input  wire                                downloading,
    input  wire                                rd_req_strobe,
    input  wire prom_pkg::prom_read_t          rd_req,
    output logic [PROM_AW-1:0]                 bank_addr,
    input  wire [prom_pkg::PROM_COUNT-1:0][7:0] bank_data,
    output logic                               rd_valid,
    output logic [7:0]                         rd_data
);

    logic               req_valid_q; // Bank read under way
    prom_pkg::prom_id_e req_id_q;    // Which bank to take
    logic               id_in_range; // Guards ids 6 and 7

    assign bank_addr   = rd_req.addr[PROM_AW-1:0]; // Shared by all banks
    assign id_in_range = int'(req_id_q) < prom_pkg::PROM_COUNT;

    always_ff @(posedge clk_rgb) begin
        if (reset) begin
            req_valid_q <= 1'b0;
            rd_valid    <= 1'b0;
        end else begin
            req_valid_q <= rd_req_strobe && !downloading;
            rd_valid    <= req_valid_q;
        end
    end

    always_ff @(posedge clk_rgb) begin
        req_id_q <= rd_req.id; // Lines up with bank output
        if (req_valid_q) begin
            rd_data <= id_in_range ? bank_data[req_id_q] : 8'h00;
        end
    end

endmodule

`default_nettype wire

// ==== source/prom_subsystem_top.sv ====
// ==================================================
// PROM subsystem top
// Download decoder, six PROM banks and the read
// mux that serves the rest of the video core
// ==================================================
`timescale 1ns/10ps
`default_nettype none

module prom_subsystem_top #(
    parameter int PROM_AW = 8 // Bank address width, 1 to 8
) (
    input  wire                        clk_rgb,
    input  wire                        reset,
    input  wire                        downloading,
    input  wire                        dl_wr,
    input  wire prom_pkg::dl_write_t   dl,
    input  wire                        rd_req_strobe,
    input  wire prom_pkg::prom_read_t  rd_req,
    output logic                       prog_we,
    output prom_pkg::prog_write_t      prog,
    output logic                       rd_valid,
    output logic [7:0]                 rd_data
);

    prom_pkg::prom_write_t                 prom_wr;   // Broadcast to banks
    logic [PROM_AW-1:0]                    bank_addr; // Shared read address
    logic [prom_pkg::PROM_COUNT-1:0][7:0]  bank_data; // One byte per bank

    prom_download_decoder u_decoder (
        .clk_rgb     (clk_rgb),
        .reset       (reset),
        .downloading (downloading),
        .dl_wr       (dl_wr),
        .dl          (dl),
        .prog_we     (prog_we),
        .prog        (prog),
        .prom_wr     (prom_wr)
    );

    for (genvar g = 0; g < prom_pkg::PROM_COUNT; g++) begin : g_bank
        prom_bank #(
            .PROM_AW (PROM_AW)
        ) u_bank (
            .clk_rgb (clk_rgb),
            .wr_en   (prom_wr.sel[g]), // Own select bit
            .wr_addr (prom_wr.addr[PROM_AW-1:0]),
            .rd_addr (bank_addr),
            .wr_data (prom_wr.data),
            .rd_data (bank_data[g])
        );
    end

    prom_read_mux #(
        .PROM_AW (PROM_AW)
    ) u_read_mux (
        .clk_rgb       (clk_rgb),
        .reset         (reset),
        .downloading   (downloading),
        .rd_req_strobe (rd_req_strobe),
        .rd_req        (rd_req),
        .bank_addr     (bank_addr),
        .bank_data     (bank_data),
        .rd_valid      (rd_valid),
        .rd_data       (rd_data)
    );

endmodule

`default_nettype wire

// ==== tb/tb_prom_subsystem.sv ====
// ==================================================
// PROM subsystem testbench
// Replays the download and read vector file against
// the PROM subsystem and checks program writes,
// PROM readback data and read latency
// ==================================================
`timescale 1ns/10ps
`default_nettype none

module tb_prom_subsystem;

    localparam int    PROM_AW  = 8;
    localparam int    WAIT_MAX = 20; // Cycles before a wait gives up
    localparam string VEC_FILE = "tb/prom_input_vectors.txt";

    typedef enum logic [2:0] {
        OP_DOWNLOAD, // D line
        OP_PROG,     // P line
        OP_READ,     // R line
        OP_SET,      // S line
        OP_BAD
    } op_e;

    logic                  clk_rgb;
    logic                  reset;
    logic                  downloading;
    logic                  dl_wr;
    prom_pkg::dl_write_t   dl;
    logic                  rd_req_strobe;
    prom_pkg::prom_read_t  rd_req;
    logic                  prog_we;
    prom_pkg::prog_write_t prog;
    logic                  rd_valid;
    logic [7:0]            rd_data;

    // Reads collect here and go out back to back
    string      rd_name_q[$];
    logic [2:0] rd_id_q[$];
    logic [7:0] rd_addr_q[$];
    logic [7:0] rd_exp_q[$];

    prom_subsystem_top #(
        .PROM_AW (PROM_AW)
    ) i_dut (
        .clk_rgb       (clk_rgb),
        .reset         (reset),
        .downloading   (downloading),
        .dl_wr         (dl_wr),
        .dl            (dl),
        .rd_req_strobe (rd_req_strobe),
        .rd_req        (rd_req),
        .prog_we       (prog_we),
        .prog          (prog),
        .rd_valid      (rd_valid),
        .rd_data       (rd_data)
    );

    initial begin
        clk_rgb = 1'b0;
        forever #2 clk_rgb = ~clk_rgb; // 4 ns period
    end

    task automatic step();
        @(posedge clk_rgb);
        #1; // Drive and sample just after the edge
    endtask

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check(input string test, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            stop_with_error($sformatf("Mismatch %s expected %h actual %h",
                                      test, expected, actual));
        end
    endtask

    function automatic op_e decode_op(input string letter);
        if (letter == "D") return OP_DOWNLOAD;
        if (letter == "P") return OP_PROG;
        if (letter == "R") return OP_READ;
        if (letter == "S") return OP_SET;
        return OP_BAD;
    endfunction

    task automatic send_download(input string name, input logic [21:0] addr,
                                 input logic [7:0] data);
        dl_wr   = 1'b1;
        dl.addr = addr;
        dl.data = data;
        step();
        dl_wr   = 1'b0; // Single-cycle strobe
        // Ignored bytes and PROM bytes raise no program write
        if (!downloading || addr >= 22'h010000) begin
            check({name, "_no_prog"}, 32'd0, {31'h0, prog_we});
        end
    endtask

    task automatic expect_prog(input string name, input logic [31:0] addr,
                               input logic [31:0] data, input logic [31:0] mask);
        int waited;
        waited = 0;
        while (!prog_we && waited < WAIT_MAX) begin
            step();
            waited++;
        end
        if (!prog_we) begin
            stop_with_error($sformatf("No program write seen for test %s", name));
        end
        check({name, "_addr"}, addr, {10'h0, prog.addr}); // Word address
        check({name, "_data"}, data, {24'h0, prog.data});
        check({name, "_mask"}, mask, {30'h0, prog.mask});
        check({name, "_latency"}, 32'd0, 32'(waited)); // Strobe at N+1
    endtask

    task automatic run_reads();
        int total;
        int issued;
        int done;
        int idle;
        int cycle;
        int issue_cycle[$];
        total  = rd_exp_q.size();
        issued = 0;
        done   = 0;
        idle   = 0;
        cycle  = 0;
        step(); // Last download reaches its bank first
        if (downloading) begin
            // Requests must vanish while the loader runs
            for (int i = 0; i < total + WAIT_MAX; i++) begin
                rd_req_strobe = (i < total);
                if (i < total) begin
                    rd_req.id   = prom_pkg::prom_id_e'(rd_id_q[i]);
                    rd_req.addr = rd_addr_q[i];
                end
                step();
                if (rd_valid) begin
                    stop_with_error("A read during download returned rd_valid");
                end
            end
        end else begin
            while (done < total) begin
                rd_req_strobe = (issued < total);
                if (issued < total) begin
                    rd_req.id   = prom_pkg::prom_id_e'(rd_id_q[issued]);
                    rd_req.addr = rd_addr_q[issued];
                    issue_cycle.push_back(cycle);
                    issued++;
                end
                step();
                cycle++;
                idle++;
                if (rd_valid) begin
                    if (done >= issued) begin
                        stop_with_error("rd_valid rose with no read pending");
                    end
                    check(rd_name_q[done], {24'h0, rd_exp_q[done]}, {24'h0, rd_data});
                    check({rd_name_q[done], "_latency"}, 32'd2,
                          32'(cycle - issue_cycle[done])); // Two cycles per read
                    done++;
                    idle = 0;
                end else if (idle > WAIT_MAX) begin
                    stop_with_error($sformatf("No read data for test %s",
                                              rd_name_q[done]));
                end
            end
        end
        rd_req_strobe = 1'b0;
        rd_name_q.delete();
        rd_id_q.delete();
        rd_addr_q.delete();
        rd_exp_q.delete();
    endtask

    initial begin
        int          fd;
        int          n;
        string       line;
        string       op_s;
        string       name;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;
        op_e         op;
        reset         = 1'b1;
        downloading   = 1'b0;
        dl_wr         = 1'b0;
        dl            = '0;
        rd_req_strobe = 1'b0;
        rd_req        = '0;
        repeat (8) @(posedge clk_rgb);
        #1;
        reset = 1'b0;
        fd = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            stop_with_error("Could not open the vector file");
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n == 0 || line.len() < 2 || line[0] == "#") continue; // Blank or comment
            n = $sscanf(line, "%s %s %h %h %h", op_s, name, f1, f2, f3);
            if (n != 5) begin
                stop_with_error($sformatf("Badly formed vector line: %s", line));
            end
            op = decode_op(op_s);
            if (op != OP_READ && rd_exp_q.size() > 0) begin
                run_reads(); // Flush the pending read burst
            end
            case (op)
                OP_DOWNLOAD: send_download(name, f1[21:0], f2[7:0]);
                OP_PROG:     expect_prog(name, f1, f2, f3);
                OP_READ: begin
                    rd_name_q.push_back(name);
                    rd_id_q.push_back(f1[2:0]);
                    rd_addr_q.push_back(f2[7:0]);
                    rd_exp_q.push_back(f3[7:0]);
                end
                OP_SET: begin
                    downloading = f1[0];
                    step();
                end
                default: stop_with_error($sformatf("Unknown opcode %s in vectors", op_s));
            endcase
        end
        if (rd_exp_q.size() > 0) begin
            run_reads();
        end
        $fclose(fd);
        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/prom_input_vectors.txt ====
# op name f1 f2 f3, fields in hex, unused fields 0
# D addr data | P word_addr data mask | R prom_id addr expected | S downloading
S dl_on 1 0 0
D prog_even 000124 a5 0
P prog_even 000092 a5 1
D prog_odd 00ffff 3c 0
P prog_odd 007fff 3c 2
D prom_timing_05 011005 11 0
D prom_objb_05 011105 22 0
D prom_obja_05 011205 33 0
D prom_back_05 011305 44 0
D prom_txt_05 010005 66 0
D prom_timing_25 011025 a1 0
D prom_objb_25 011125 a2 0
D prom_obja_25 011225 a3 0
D prom_txtpal_25 011325 a5 0
D prom_txt_25 010025 a6 0
D prom_txt_first 010000 c3 0
D prom_txt_70 010370 77 0
D prom_objb_40 013140 5b 0
D prog_alias 000005 ee 0
P prog_alias 000002 ee 2
S dl_off 0 0 0
R rd_timing_05 0 05 11
R rd_objb_05 1 05 22
R rd_obja_05 2 05 33
R rd_back_05 3 05 44
R rd_txt_05 5 05 66
R rd_timing_25 0 25 a1
R rd_objb_25 1 25 a2
R rd_obja_25 2 25 a3
R rd_txtpal_25 4 25 a5
R rd_txt_25 5 25 a6
R rd_txt_first 5 00 c3
R rd_txt_70 5 70 77
R rd_objb_40 1 40 5b
D ignored_wr 011005 ff 0
R rd_after_ignored 0 05 11
S dl_on_again 1 0 0
R drop_rd 0 05 0
S dl_off_again 0 0 0
R rd_final 3 05 44

// ==== files.f ====
source/prom_pkg.sv
source/prom_download_decoder.sv
source/prom_bank.sv
source/prom_read_mux.sv
source/prom_subsystem_top.sv
tb/tb_prom_subsystem.sv

// ==== Makefile ====
# Verilator flow for the PROM download subsystem
# Run from the project root so the vector file path resolves

VERILATOR   ?= verilator
TOP         ?= tb_prom_subsystem
RTL_TOP     ?= prom_subsystem_top
FILELIST    ?= files.f
RTL_SRCS    ?= source/prom_pkg.sv source/prom_download_decoder.sv \
               source/prom_bank.sv source/prom_read_mux.sv source/prom_subsystem_top.sv
OBJ_DIR     ?= obj_dir
LINT_FLAGS  ?= --lint-only --timing
BUILD_FLAGS ?= --binary --timing -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) $(RTL_SRCS) --top-module $(RTL_TOP)
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(BUILD_FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
